/* design/cpu_pkg.sv */
// Shared types, opcode and condition encodings, and instruction field positions for the core
`default_nettype none

package cpu_pkg;

	localparam int WORD_W = 16;                     // Machine word width

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [3:0]        reg_addr_t;

	// Opcode map, ALU group first
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SUB  = 4'b0001,
		NAND = 4'b0010,
		XOR  = 4'b0011,
		INC  = 4'b0100,
		SRA  = 4'b0101,
		SRL  = 4'b0110,
		SLL  = 4'b0111,
		LW   = 4'b1000,
		SW   = 4'b1001,
		LHB  = 4'b1010,
		LLB  = 4'b1011,
		B    = 4'b1100,
		CALL = 4'b1101,
		RET  = 4'b1110,
		ERR  = 4'b1111
	} opcode_t;

	// Branch conditions, tested against the flag register
	typedef enum logic [2:0] {
		EQ = 3'b000,
		LT = 3'b001,
		GT = 3'b010,
		OV = 3'b011,
		NE = 3'b100,
		GE = 3'b101,
		LE = 3'b110,
		TR = 3'b111
	} cond_t;

	typedef logic [2:0] alu_op_t;                   // Same as low opcode bits

	localparam alu_op_t ALU_ADD  = 3'b000;
	localparam alu_op_t ALU_SUB  = 3'b001;
	localparam alu_op_t ALU_NAND = 3'b010;
	localparam alu_op_t ALU_XOR  = 3'b011;
	localparam alu_op_t ALU_INC  = 3'b100;
	localparam alu_op_t ALU_SRA  = 3'b101;
	localparam alu_op_t ALU_SRL  = 3'b110;
	localparam alu_op_t ALU_SLL  = 3'b111;

	typedef enum logic [1:0] {
		LD_NONE = 2'b00,                            // Normal ALU result
		LD_HIGH = 2'b01,                            // LHB, replace upper byte
		LD_LOW  = 2'b10                             // LLB, sign-extended byte
	} ld_byte_t;

	localparam reg_addr_t DS_REG   = 4'd14;         // Data segment base
	localparam reg_addr_t LINK_REG = 4'd15;         // Return address for CALL/RET

	localparam word_t NOP_WORD = 16'h0000;          // ADD r0,r0,r0

	// Instruction field positions
	localparam int OP_HI  = 15;
	localparam int OP_LO  = 12;
	localparam int RD_HI  = 11;
	localparam int RD_LO  = 8;
	localparam int CND_HI = 10;                     // Condition sits in low bits of rd
	localparam int CND_LO = 8;
	localparam int RS_HI  = 7;
	localparam int RS_LO  = 4;
	localparam int RT_HI  = 3;                      // Also the shift amount
	localparam int RT_LO  = 0;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;
	localparam int TGT_HI = 11;                     // CALL absolute target
	localparam int TGT_LO = 0;

endpackage

`default_nettype wire

/* design/control_logic.sv */
// Control decoder, maps opcode and branch condition onto datapath control signals
`timescale 1ns/1ns
`default_nettype none

module control_logic (
	input  cpu_pkg::opcode_t  opcode,
	input  cpu_pkg::cond_t    branch_cond,
	output logic              data_reg,    // First operand from r14
	output logic              call,
	output logic              rtrn,        // First operand from r15, jump to it
	output logic [3:0]        branch,      // Taken-capable bit, then condition
	output logic              mem_to_reg,
	output logic              reg_to_mem,
	output logic              alu_src,     // Immediate as second operand
	output logic              sign_ext,
	output logic              reg_write,
	output logic              halt,
	output cpu_pkg::alu_op_t  alu_op,
	output cpu_pkg::ld_byte_t ld_byte
);
	import cpu_pkg::*;

	always_comb begin
		// Quiet defaults, each opcode only raises what it needs
		data_reg   = 1'b0;
		call       = 1'b0;
		rtrn       = 1'b0;
		branch     = {1'b0, branch_cond};
		mem_to_reg = 1'b0;
		reg_to_mem = 1'b0;
		alu_src    = 1'b0;
		sign_ext   = 1'b0;
		reg_write  = 1'b0;
		halt       = 1'b0;
		alu_op     = ALU_ADD;
		ld_byte    = LD_NONE;

		case (opcode)
			ADD, SUB, NAND, XOR, INC: begin
				alu_op    = opcode[2:0];
				reg_write = 1'b1;
			end
			SRA, SRL, SLL: begin
				alu_op    = opcode[2:0];
				alu_src   = 1'b1;                   // Shift amount from rt field
				reg_write = 1'b1;
			end
			LW: begin
				data_reg   = 1'b1;
				mem_to_reg = 1'b1;
				alu_src    = 1'b1;
				sign_ext   = 1'b1;
				reg_write  = 1'b1;
			end
			SW: begin
				data_reg   = 1'b1;
				reg_to_mem = 1'b1;
				alu_src    = 1'b1;
				sign_ext   = 1'b1;
			end
			LHB: begin
				alu_src   = 1'b1;
				reg_write = 1'b1;
				ld_byte   = LD_HIGH;
			end
			LLB: begin
				alu_src   = 1'b1;
				reg_write = 1'b1;
				ld_byte   = LD_LOW;
			end
			B: begin
				branch   = {1'b1, branch_cond};
				alu_op   = ALU_SUB;                 // Compare form
				alu_src  = 1'b1;
				sign_ext = 1'b1;                    // Signed displacement
			end
			CALL: begin
				call      = 1'b1;
				reg_write = 1'b1;                   // Link into r15
			end
			RET:     rtrn = 1'b1;
			default: halt = 1'b1;                   // ERR and anything unknown
		endcase
	end

endmodule

`default_nettype wire

/* design/reg_file.sv */
// Register file, sixteen 16-bit registers with two write-first read ports and r0 tied to zero
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t rs_addr,
	input  cpu_pkg::reg_addr_t rt_addr,
	output cpu_pkg::word_t     rs_data,
	output cpu_pkg::word_t     rt_data,
	input  logic               we,
	input  cpu_pkg::reg_addr_t wd_addr,
	input  cpu_pkg::word_t     wd_data
);
	import cpu_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we && wd_addr != '0) begin
			regs[wd_addr] <= wd_data;               // r0 never written
		end
	end

	// Same-cycle write shows through on either port
	always_comb begin
		if (rs_addr == '0)
			rs_data = '0;
		else if (we && wd_addr == rs_addr)
			rs_data = wd_data;
		else
			rs_data = regs[rs_addr];

		if (rt_addr == '0)
			rt_data = '0;
		else if (we && wd_addr == rt_addr)
			rt_data = wd_data;
		else
			rt_data = regs[rt_addr];
	end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
// Fetch stage, program counter with redirect and halt, plus the fetch pipeline register
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input  logic           clk,
	input  logic           rst,
	input  logic           redirect,
	input  cpu_pkg::word_t redirect_pc,
	input  logic           halt_req,
	output cpu_pkg::word_t imem_addr,
	input  cpu_pkg::word_t imem_data,
	output cpu_pkg::word_t pc_f,
	output cpu_pkg::word_t instr_f,
	output logic           valid_f,
	output logic           halted
);
	import cpu_pkg::*;

	word_t pc;
	logic  flush;

	assign imem_addr = pc;                          // Instruction memory reads combinationally
	assign flush     = redirect | halt_req | halted;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= '0;
			valid_f <= 1'b0;
			halted  <= 1'b0;
		end else begin
			if (halt_req)
				halted <= 1'b1;                     // Sticky until reset
			if (!(halt_req || halted))              // PC frozen once ERR seen
				pc <= redirect ? redirect_pc : pc + 16'd1;
			valid_f <= !flush;
		end
	end

	// Payload, a flushed slot carries a NOP
	always_ff @(posedge clk) begin
		pc_f    <= pc;
		instr_f <= flush ? NOP_WORD : imem_data;
	end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// Decode stage, field split, immediate extension, register reads and the decode pipeline register
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush,
	input  cpu_pkg::word_t      pc_f,
	input  cpu_pkg::word_t      instr_f,
	input  logic                valid_f,
	output cpu_pkg::reg_addr_t  rs_addr,
	output cpu_pkg::reg_addr_t  rt_addr,
	input  cpu_pkg::word_t      rs_data,
	input  cpu_pkg::word_t      rt_data,
	output logic                valid_d,
	output logic                call_d,
	output logic                rtrn_d,
	output logic [3:0]          branch_d,
	output logic                mem_to_reg_d,
	output logic                reg_to_mem_d,
	output logic                alu_src_d,
	output logic                reg_write_d,
	output logic                halt_d,
	output cpu_pkg::alu_op_t    alu_op_d,
	output cpu_pkg::ld_byte_t   ld_byte_d,
	output cpu_pkg::word_t      a_d,
	output cpu_pkg::word_t      b_d,
	output cpu_pkg::word_t      imm_d,
	output cpu_pkg::reg_addr_t  rd_d,
	output cpu_pkg::word_t      pc_plus1_d
);
	import cpu_pkg::*;

	logic       data_reg, call, rtrn, mem_to_reg, reg_to_mem;
	logic       alu_src, sign_ext, reg_write, halt;
	logic [3:0] branch;
	alu_op_t    alu_op;
	ld_byte_t   ld_byte;
	reg_addr_t  rd;
	logic [7:0] imm8;
	word_t      imm;

	control_logic i_ctrl (
		.opcode      (opcode_t'(instr_f[OP_HI:OP_LO])),
		.branch_cond (cond_t'(instr_f[CND_HI:CND_LO])),
		.data_reg    (data_reg),
		.call        (call),
		.rtrn        (rtrn),
		.branch      (branch),
		.mem_to_reg  (mem_to_reg),
		.reg_to_mem  (reg_to_mem),
		.alu_src     (alu_src),
		.sign_ext    (sign_ext),
		.reg_write   (reg_write),
		.halt        (halt),
		.alu_op      (alu_op),
		.ld_byte     (ld_byte)
	);

	assign rd   = instr_f[RD_HI:RD_LO];
	assign imm8 = instr_f[IMM_HI:IMM_LO];

	// First port: r14 base for LW/SW, r15 for RET
	assign rs_addr = data_reg ? DS_REG : rtrn ? LINK_REG : instr_f[RS_HI:RS_LO];
	// Second port reads rd for store data and for LHB's kept low byte
	assign rt_addr = (reg_to_mem || ld_byte == LD_HIGH) ? rd : instr_f[RT_HI:RT_LO];

	always_comb begin
		if (call)
			imm = {4'h0, instr_f[TGT_HI:TGT_LO]};  // Absolute call target
		else if (sign_ext)
			imm = {{8{imm8[7]}}, imm8};
		else
			imm = {8'h00, imm8};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_d      <= 1'b0;
			call_d       <= 1'b0;
			rtrn_d       <= 1'b0;
			branch_d     <= '0;
			mem_to_reg_d <= 1'b0;
			reg_to_mem_d <= 1'b0;
			reg_write_d  <= 1'b0;
			halt_d       <= 1'b0;
		end else begin
			valid_d      <= valid_f & !flush;       // Squash the slot behind a redirect
			call_d       <= call;
			rtrn_d       <= rtrn;
			branch_d     <= branch;
			mem_to_reg_d <= mem_to_reg;
			reg_to_mem_d <= reg_to_mem;
			reg_write_d  <= reg_write;
			halt_d       <= halt;
		end
	end

	always_ff @(posedge clk) begin
		alu_src_d  <= alu_src;
		alu_op_d   <= alu_op;
		ld_byte_d  <= ld_byte;
		a_d        <= rs_data;
		b_d        <= rt_data;
		imm_d      <= imm;
		rd_d       <= call ? LINK_REG : rd;     // CALL links into r15
		pc_plus1_d <= pc_f + 16'd1;
	end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// Execute stage, ALU and flags, branch/call/return resolution and the execute pipeline register
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               valid_d,
	input  logic               call_d,
	input  logic               rtrn_d,
	input  logic [3:0]         branch_d,
	input  logic               mem_to_reg_d,
	input  logic               reg_to_mem_d,
	input  logic               alu_src_d,
	input  logic               reg_write_d,
	input  logic               halt_d,
	input  cpu_pkg::alu_op_t   alu_op_d,
	input  cpu_pkg::ld_byte_t  ld_byte_d,
	input  cpu_pkg::word_t     a_d,
	input  cpu_pkg::word_t     b_d,
	input  cpu_pkg::word_t     imm_d,
	input  cpu_pkg::reg_addr_t rd_d,
	input  cpu_pkg::word_t     pc_plus1_d,
	output logic               redirect,
	output cpu_pkg::word_t     redirect_pc,
	output logic               halt_req,
	output cpu_pkg::word_t     result_x,
	output cpu_pkg::word_t     store_x,
	output cpu_pkg::reg_addr_t rd_x,
	output logic               mem_to_reg_x,
	output logic               reg_to_mem_x,
	output logic               reg_write_x,
	output logic               valid_x
);
	import cpu_pkg::*;

	word_t alu_b, alu_res, result;
	logic  ovf, flag_en, cond_ok, taken;
	logic  flag_z, flag_v, flag_n;                  // Flag register

	assign alu_b = alu_src_d ? imm_d : b_d;

	always_comb begin
		ovf = 1'b0;                                 // Only add/sub/inc can overflow
		case (alu_op_d)
			ALU_ADD: begin
				alu_res = a_d + alu_b;
				ovf     = (a_d[15] == alu_b[15]) && (alu_res[15] != a_d[15]);
			end
			ALU_SUB: begin
				alu_res = a_d - alu_b;
				ovf     = (a_d[15] != alu_b[15]) && (alu_res[15] != a_d[15]);
			end
			ALU_NAND: alu_res = ~(a_d & alu_b);
			ALU_XOR:  alu_res = a_d ^ alu_b;
			ALU_INC: begin
				alu_res = a_d + 16'd1;
				ovf     = !a_d[15] && alu_res[15];  // 7FFF wraps
			end
			ALU_SRA:  alu_res = word_t'($signed(a_d) >>> alu_b[3:0]);
			ALU_SRL:  alu_res = a_d >> alu_b[3:0];
			default:  alu_res = a_d << alu_b[3:0];  // SLL
		endcase

		case (ld_byte_d)
			LD_HIGH: result = {imm_d[7:0], b_d[7:0]};   // Keep rd's low byte
			LD_LOW:  result = {{8{imm_d[7]}}, imm_d[7:0]};
			default: result = call_d ? pc_plus1_d : alu_res;
		endcase
	end

	// Flags follow plain ALU ops only, not loads, stores, branches or links
	assign flag_en = valid_d && reg_write_d && !mem_to_reg_d && !call_d
	                 && ld_byte_d == LD_NONE;

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_v <= 1'b0;
			flag_n <= 1'b0;
		end else if (flag_en) begin
			flag_z <= (result == '0);
			flag_v <= ovf;
			flag_n <= result[15];
		end
	end

	always_comb begin
		case (cond_t'(branch_d[2:0]))
			EQ:      cond_ok = flag_z;
			LT:      cond_ok = flag_n;
			GT:      cond_ok = !flag_z && !flag_n;
			OV:      cond_ok = flag_v;
			NE:      cond_ok = !flag_z;
			GE:      cond_ok = !flag_n;
			LE:      cond_ok = flag_n || flag_z;
			default: cond_ok = 1'b1;                // TR
		endcase
	end

	assign taken       = branch_d[3] && cond_ok;
	assign redirect    = valid_d && (taken || call_d || rtrn_d);
	assign redirect_pc = rtrn_d ? a_d : call_d ? imm_d : pc_plus1_d + imm_d;
	assign halt_req    = valid_d && halt_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_x      <= 1'b0;
			mem_to_reg_x <= 1'b0;
			reg_to_mem_x <= 1'b0;
			reg_write_x  <= 1'b0;
		end else begin
			valid_x      <= valid_d;
			mem_to_reg_x <= mem_to_reg_d;
			reg_to_mem_x <= reg_to_mem_d;
			reg_write_x  <= reg_write_d;
		end
	end

	always_ff @(posedge clk) begin
		result_x <= result;                         // Also the data address for LW/SW
		store_x  <= b_d;
		rd_x     <= rd_d;
	end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
// Memory stage, data memory access and writeback selection into the register file
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
	input  logic               valid_x,
	input  cpu_pkg::word_t     result_x,
	input  cpu_pkg::word_t     store_x,
	input  cpu_pkg::reg_addr_t rd_x,
	input  logic               mem_to_reg_x,
	input  logic               reg_to_mem_x,
	input  logic               reg_write_x,
	output cpu_pkg::word_t     dmem_addr,
	output cpu_pkg::word_t     dmem_wdata,
	output logic               dmem_we,
	output logic               dmem_re,
	input  cpu_pkg::word_t     dmem_rdata,
	output logic               we,
	output cpu_pkg::reg_addr_t wd_addr,
	output cpu_pkg::word_t     wd_data
);

	assign dmem_addr  = result_x;                   // r14 plus offset from execute
	assign dmem_wdata = store_x;
	assign dmem_we    = valid_x & reg_to_mem_x;     // One cycle per store
	assign dmem_re    = valid_x & mem_to_reg_x;

	// Load data arrives in the same cycle
	assign wd_data = mem_to_reg_x ? dmem_rdata : result_x;
	assign wd_addr = rd_x;
	assign we      = valid_x & reg_write_x;         // Flushed slots write nothing

endmodule

`default_nettype wire

/* design/cpu_top.sv */
// Core top level, wires the four pipeline stages to the register file and memory ports
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  logic           clk,
	input  logic           rst,
	output cpu_pkg::word_t imem_addr,
	input  cpu_pkg::word_t imem_data,
	output cpu_pkg::word_t dmem_addr,
	output cpu_pkg::word_t dmem_wdata,
	output logic           dmem_we,
	output logic           dmem_re,
	input  cpu_pkg::word_t dmem_rdata,
	output logic           halted
);
	import cpu_pkg::*;

	logic       redirect, halt_req, valid_f;
	word_t      redirect_pc, pc_f, instr_f;
	reg_addr_t  rs_addr, rt_addr, wd_addr, rd_d, rd_x;
	word_t      rs_data, rt_data, wd_data;
	logic       we;
	logic       valid_d, call_d, rtrn_d, mem_to_reg_d, reg_to_mem_d;
	logic       alu_src_d, reg_write_d, halt_d;
	logic [3:0] branch_d;
	alu_op_t    alu_op_d;
	ld_byte_t   ld_byte_d;
	word_t      a_d, b_d, imm_d, pc_plus1_d;
	word_t      result_x, store_x;
	logic       mem_to_reg_x, reg_to_mem_x, reg_write_x, valid_x;

	fetch_stage i_fetch (
		.clk, .rst, .redirect, .redirect_pc, .halt_req,
		.imem_addr, .imem_data, .pc_f, .instr_f, .valid_f, .halted
	);

	decode_stage i_decode (
		.clk, .rst,
		.flush (redirect | halt_req),               // Slot right behind the resolver
		.pc_f, .instr_f, .valid_f,
		.rs_addr, .rt_addr, .rs_data, .rt_data,
		.valid_d, .call_d, .rtrn_d, .branch_d, .mem_to_reg_d, .reg_to_mem_d,
		.alu_src_d, .reg_write_d, .halt_d, .alu_op_d, .ld_byte_d,
		.a_d, .b_d, .imm_d, .rd_d, .pc_plus1_d
	);

	reg_file i_regs (
		.clk, .rst, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.we, .wd_addr, .wd_data
	);

	execute_stage i_execute (
		.clk, .rst,
		.valid_d, .call_d, .rtrn_d, .branch_d, .mem_to_reg_d, .reg_to_mem_d,
		.alu_src_d, .reg_write_d, .halt_d, .alu_op_d, .ld_byte_d,
		.a_d, .b_d, .imm_d, .rd_d, .pc_plus1_d,
		.redirect, .redirect_pc, .halt_req,
		.result_x, .store_x, .rd_x, .mem_to_reg_x, .reg_to_mem_x, .reg_write_x, .valid_x
	);

	memory_stage i_memory (
		.valid_x, .result_x, .store_x, .rd_x, .mem_to_reg_x, .reg_to_mem_x, .reg_write_x,
		.dmem_addr, .dmem_wdata, .dmem_we, .dmem_re, .dmem_rdata,
		.we, .wd_addr, .wd_data
	);

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// Testbench clock source, 4 ns period clock and a power-on reset held for 16 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;                      // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;                                // Released on a rising edge
	end

endmodule

`default_nettype wire

/* tb/cpu_tb.sv */
// Testbench for the pipelined core with memory models, directed program tests and bus checks
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	logic  clk, rst_init, rst;
	logic  rst_task = 1'b0;                         // Reset driven by the test tasks
	word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
	logic  dmem_we, dmem_re, halted;

	word_t  imem [256];
	word_t  dmem [256];
	word_t  log_addr[$], log_data[$];               // Stores seen on the bus
	word_t  exp_addr[$], exp_data[$];               // Stores the program should make
	int     loads = 0;                              // Read cycles seen on the bus
	int     wp, prog_len;
	int     budget = 64;                            // Watchdog limit that grows per program
	int     cycles = 0;
	int     value_errors = 0;
	int     other_errors = 0;
	integer seed = 32'hec394a95;

	assign rst = rst_init | rst_task;

	tb_clock i_clock (.clk(clk), .rst(rst_init));

	cpu_top i_dut (
		.clk, .rst, .imem_addr, .imem_data,
		.dmem_addr, .dmem_wdata, .dmem_we, .dmem_re, .dmem_rdata, .halted
	);

	// Both memories answer in the same cycle
	assign imem_data  = imem[imem_addr[7:0]];
	assign dmem_rdata = dmem_re ? dmem[dmem_addr[7:0]] : '0;

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[7:0]] <= dmem_wdata;
			log_addr.push_back(dmem_addr);          // Every store kept in order
			log_data.push_back(dmem_wdata);
		end
		if (dmem_re)
			loads++;
	end

	// Instruction builders
	function automatic word_t alu_instr(opcode_t op, reg_addr_t rd, reg_addr_t rs, logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word_t imm_instr(opcode_t op, reg_addr_t rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic word_t branch_instr(cond_t c, logic [7:0] disp);
		return {B, 1'b0, c, disp};
	endfunction

	function automatic word_t call_instr(logic [11:0] target);
		return {CALL, target};
	endfunction

	// Branch conditions against Z, N and V
	function automatic logic cond_holds(cond_t c, logic z, logic n, logic v);
		case (c)
			EQ:      return z;
			LT:      return n;
			GT:      return !z && !n;
			OV:      return v;
			NE:      return !z;
			GE:      return !n;
			LE:      return n || z;
			default: return 1'b1;
		endcase
	endfunction

	task automatic compare_word(string what, word_t got, word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] t=%0t %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(string what, logic got, logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] t=%0t %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Holds the core in reset while memories and logs are refilled
	task automatic begin_program();
		@(posedge clk);
		rst_task <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < 256; i++) begin
			imem[i] = {ERR, 4'h0, 8'(i)};           // Stray fetches halt
			dmem[i] <= {8'(i) ^ 8'hA5, 8'(i)};
		end
		log_addr.delete();
		log_data.delete();
		exp_addr.delete();
		exp_data.delete();
		loads    = 0;
		wp       = 0;
		prog_len = 0;
		budget   += 8;
	endtask

	task automatic emit(word_t w);
		imem[wp] = w;
		wp++;
		if (wp > prog_len)
			prog_len = wp;
	endtask

	task automatic org(int at);
		wp = at;
	endtask

	task automatic pad(int n);
		repeat (n) emit(NOP_WORD);                  // Spacing for dependent instructions
	endtask

	task automatic expect_store(word_t addr, word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// Releases reset and waits for ERR to halt the core
	task automatic run_program();
		budget += prog_len * 20;
		@(posedge clk);
		rst_task <= 1'b0;
		while (halted !== 1'b1)
			@(posedge clk);
		repeat (2) @(posedge clk);                  // Older stores drain
	endtask

	task automatic check_bus(string name, int exp_loads);
		int n;
		n = log_addr.size();
		if (loads != exp_loads) begin
			other_errors++;
			$display("%s: saw %0d loads but expected %0d", name, loads, exp_loads);
		end
		if (n != exp_addr.size()) begin
			other_errors++;
			$display("%s: saw %0d stores but expected %0d", name, n, exp_addr.size());
			if (exp_addr.size() < n)
				n = exp_addr.size();
		end
		for (int i = 0; i < n; i++) begin
			compare_word($sformatf("%s store %0d dmem_addr", name, i), log_addr[i], exp_addr[i]);
			compare_word($sformatf("%s store %0d dmem_wdata", name, i), log_data[i], exp_data[i]);
		end
	endtask

	task automatic alu_ops();
		word_t      a, b;
		word_t      res [8];
		logic [3:0] sh;
		a  = word_t'($random(seed));
		b  = word_t'($random(seed));
		sh = 4'($random(seed));
		begin_program();
		emit(imm_instr(LLB, 4'd1, a[7:0]));
		emit(imm_instr(LLB, 4'd2, b[7:0]));
		emit(imm_instr(LLB, DS_REG, 8'h40));
		emit(imm_instr(LHB, 4'd1, a[15:8]));        // Upper bytes on top of the low ones
		emit(imm_instr(LHB, 4'd2, b[15:8]));
		pad(2);
		emit(alu_instr(ADD, 4'd3, 4'd1, 4'd2));
		emit(alu_instr(SUB, 4'd4, 4'd1, 4'd2));
		emit(alu_instr(NAND, 4'd5, 4'd1, 4'd2));
		emit(alu_instr(XOR, 4'd6, 4'd1, 4'd2));
		emit(alu_instr(INC, 4'd7, 4'd1, 4'd0));
		emit(alu_instr(SRA, 4'd8, 4'd1, sh));
		emit(alu_instr(SRL, 4'd9, 4'd1, sh));
		emit(alu_instr(SLL, 4'd10, 4'd1, sh));
		res[0] = a + b;
		res[1] = a - b;
		res[2] = ~(a & b);
		res[3] = a ^ b;
		res[4] = a + 16'd1;
		res[5] = (a >> sh) | ({16{a[15]}} & ~(16'hFFFF >> sh));  // Sign bit fills the top
		res[6] = a >> sh;
		res[7] = a << sh;
		for (int i = 0; i < 8; i++) begin
			emit(imm_instr(SW, reg_addr_t'(3 + i), 8'(i)));
			expect_store(word_t'(64 + i), res[i]);
		end
		emit(alu_instr(ERR, 4'd0, 4'd0, 4'd0));
		run_program();
		check_bus("alu", 0);
	endtask

	task automatic load_store();
		word_t v;
		v = word_t'($random(seed));
		begin_program();
		emit(imm_instr(LLB, DS_REG, 8'h40));
		emit(imm_instr(LLB, 4'd1, v[7:0]));
		pad(2);
		emit(imm_instr(LHB, 4'd1, v[15:8]));
		emit(imm_instr(LLB, 4'd3, 8'h9A));          // Negative byte that sign-extends
		pad(1);
		emit(imm_instr(SW, 4'd1, 8'hFC));           // r14 - 4
		emit(imm_instr(LW, 4'd2, 8'hFC));
		pad(2);
		emit(imm_instr(SW, 4'd2, 8'h05));
		emit(imm_instr(SW, 4'd3, 8'h00));
		emit(alu_instr(ERR, 4'd0, 4'd0, 4'd0));
		expect_store(16'h003C, v);
		expect_store(16'h0045, v);                  // Value read back by LW
		expect_store(16'h0040, 16'hFF9A);
		run_program();
		check_bus("load/store", 1);
	endtask

	task automatic branch_conds();
		word_t x, y, r;
		logic  z, n, v, add, taken;
		int    blk;
		begin_program();
		emit(imm_instr(LLB, DS_REG, 8'h40));
		emit(imm_instr(LLB, 4'd1, 8'd5));
		emit(imm_instr(LLB, 4'd3, 8'd3));
		emit(imm_instr(LLB, 4'd7, 8'hFF));
		emit(imm_instr(LLB, 4'd5, 8'h11));          // Fall-through marker
		emit(imm_instr(LLB, 4'd6, 8'h22));          // Join marker
		pad(1);
		emit(imm_instr(LHB, 4'd7, 8'h7F));          // r7 = 7FFF
		pad(2);
		for (int c = 0; c < 8; c++) begin
			for (int sel = 0; sel < 4; sel++) begin
				blk = c * 4 + sel;
				case (sel)
					0: begin
						x   = 16'd5;
						y   = 16'd5;
						add = 1'b0;
						emit(alu_instr(SUB, 4'd8, 4'd1, 4'd1));
					end
					1: begin
						x   = 16'd5;
						y   = 16'd3;
						add = 1'b0;
						emit(alu_instr(SUB, 4'd8, 4'd1, 4'd3));
					end
					2: begin
						x   = 16'd3;
						y   = 16'd5;
						add = 1'b0;
						emit(alu_instr(SUB, 4'd8, 4'd3, 4'd1));
					end
					default: begin
						x   = 16'h7FFF;                 // Signed overflow
						y   = 16'h7FFF;
						add = 1'b1;
						emit(alu_instr(ADD, 4'd8, 4'd7, 4'd7));
					end
				endcase
				r = add ? x + y : x - y;
				if (add)
					v = (x[15] == y[15]) && (r[15] != x[15]);
				else
					v = (x[15] != y[15]) && (r[15] != x[15]);
				z     = (r == '0);
				n     = r[15];
				taken = cond_holds(cond_t'(c), z, n, v);
				emit(branch_instr(cond_t'(c), 8'd1));  // Skips one store when taken
				emit(imm_instr(SW, 4'd5, 8'(blk)));
				emit(imm_instr(SW, 4'd6, 8'(32 + blk)));
				if (!taken)
					expect_store(word_t'(64 + blk), 16'h0011);
				expect_store(word_t'(96 + blk), 16'h0022);
			end
		end
		emit(alu_instr(ERR, 4'd0, 4'd0, 4'd0));
		run_program();
		check_bus("branch", 0);
	endtask

	task automatic call_return();
		begin_program();
		emit(imm_instr(LLB, DS_REG, 8'h40));
		emit(imm_instr(LLB, 4'd1, 8'h31));
		emit(imm_instr(LLB, 4'd2, 8'h32));
		emit(imm_instr(LLB, 4'd3, 8'h33));
		emit(imm_instr(SW, 4'd1, 8'h00));
		emit(call_instr(12'd20));                   // Link is 6
		emit(imm_instr(SW, 4'd3, 8'h02));           // Runs only after RET
		emit(alu_instr(ERR, 4'd0, 4'd0, 4'd0));
		org(20);
		emit(imm_instr(SW, 4'd2, 8'h01));
		emit(imm_instr(SW, LINK_REG, 8'h03));
		emit(alu_instr(RET, 4'd0, 4'd0, 4'd0));
		emit(imm_instr(SW, 4'd1, 8'h09));           // Flushed behind RET
		emit(imm_instr(SW, 4'd1, 8'h0A));
		expect_store(16'h0040, 16'h0031);
		expect_store(16'h0041, 16'h0032);
		expect_store(16'h0043, 16'h0006);
		expect_store(16'h0042, 16'h0033);
		run_program();
		check_bus("call/ret", 0);
	endtask

	task automatic err_halt();
		begin_program();
		emit(imm_instr(LLB, DS_REG, 8'h40));
		emit(imm_instr(LLB, 4'd1, 8'h55));
		pad(2);
		emit(imm_instr(SW, 4'd1, 8'h00));
		emit(alu_instr(ERR, 4'd0, 4'd0, 4'd0));
		emit(imm_instr(SW, 4'd1, 8'h01));           // None of these may store
		emit(imm_instr(SW, 4'd1, 8'h02));
		emit(imm_instr(SW, 4'd1, 8'h03));
		expect_store(16'h0040, 16'h0055);
		run_program();
		repeat (8) begin
			@(posedge clk);
			compare_bit("halted", halted, 1'b1);   // Sticky
		end
		check_bus("err", 0);
	endtask

	task automatic reset_restart();
		word_t v;
		v = word_t'($random(seed));
		begin_program();
		emit(imm_instr(LLB, DS_REG, 8'h40));
		emit(imm_instr(LLB, 4'd1, v[7:0]));
		pad(2);
		emit(imm_instr(LHB, 4'd1, v[15:8]));
		pad(2);
		emit(imm_instr(SW, 4'd1, 8'h00));
		emit(alu_instr(ERR, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0040, v);
		run_program();
		compare_bit("halted", halted, 1'b1);
		@(posedge clk);
		rst_task <= 1'b1;
		repeat (2) @(posedge clk);
		compare_bit("halted", halted, 1'b0);       // Cleared by reset
		expect_store(16'h0040, v);                  // Same first store again
		run_program();
		check_bus("reset restart", 0);
	endtask

	// Watchdog
	initial begin
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the DUT did not halt within %0d cycles", budget);
		$display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		wait (rst_init === 1'b1);
		wait (rst_init === 1'b0);
		alu_ops();
		load_store();
		branch_conds();
		call_return();
		err_halt();
		reset_restart();
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
design/cpu_pkg.sv
design/control_logic.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
tb/tb_clock.sv
tb/cpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = cpu_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
